// ==== project.f ====
source/lsu_pkg.sv
source/agu.sv
source/lsu.sv
source/dram.sv
source/mem_ctrl.sv
source/mem_unit.sv
verif/mem_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run the memory stage testbench
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module mem_unit_tb -o mem_unit_sim

# The simulator exits non-zero on failure; the verdict comes from its output
out=$(./obj_dir/mem_unit_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Verification passed"; then
   exit 0
fi
exit 1

// ==== source/agu.sv ====
`timescale 1ns/1ps

module agu
(
   input  logic [63:0] base,
   input  logic [63:0] offset,
   input  logic [3:0]  size,
   output logic [63:0] addr,
   output logic        misaligned
);

   import lsu_pkg::*;

   assign addr = base + offset; // Effective address

   // Natural alignment per access size
   always_comb
   begin
      case (size)
         SIZE_B:
         begin
            misaligned = 1'b0;
         end
         SIZE_H:
         begin
            misaligned = addr[0];
         end
         SIZE_W:
         begin
            misaligned = |addr[1:0];
         end
         default:
         begin
            misaligned = |addr[2:0]; // Odd codes behave as doubleword
         end
      endcase
   end

endmodule

// ==== source/dram.sv ====
`timescale 1ns/1ps

module dram #(
   parameter int AW = lsu_pkg::DRAM_AW
)
(
   input  logic               clk,
   input  logic [AW-1:0]      addr,
   input  logic [7:0]         we,
   input  logic               re,
   input  logic [63:0]        din,
   output lsu_pkg::mem_word_u dout
);

   localparam int DEPTH = 2 ** (AW - 3);

   logic [63:0]   mem [0:DEPTH-1];
   logic [AW-4:0] word_idx;

   assign word_idx = addr[AW-1:3]; // Doubleword index

   // Per-byte write
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 8; i++)
      begin
         if (we[i])
         begin
            mem[word_idx][i*8 +: 8] <= din[i*8 +: 8];
         end
      end
   end

   // Read-before-write on the same edge
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         dout.d <= mem[word_idx];
      end
   end

endmodule

// ==== source/lsu.sv ====
`timescale 1ns/1ps

module lsu #(
   parameter int AW = lsu_pkg::DRAM_AW
)
(
   input  logic [63:0]        addr,
   input  logic [3:0]         size,
   input  logic [63:0]        wdata,
   input  logic               store_en,
   input  lsu_pkg::load_ctx_t ctx,
   input  lsu_pkg::mem_word_u rdata,
   output logic [AW-1:0]      dram_addr,
   output logic [7:0]         dram_we,
   output logic [63:0]        dram_din,
   output logic [63:0]        ld_value
);

   import lsu_pkg::*;

   logic [7:0]  lane_mask;
   logic [7:0]  ld_b;
   logic [15:0] ld_h;
   logic [31:0] ld_w;

   assign dram_addr = addr[AW-1:0]; // Upper bits alias

   // ------------------------------
   // Store side
   // ------------------------------

   // Replicate the low part so every lane holds it
   always_comb
   begin
      case (size)
         SIZE_B:
         begin
            dram_din = {8{wdata[7:0]}};
         end
         SIZE_H:
         begin
            dram_din = {4{wdata[15:0]}};
         end
         SIZE_W:
         begin
            dram_din = {2{wdata[31:0]}};
         end
         default:
         begin
            dram_din = wdata;
         end
      endcase
   end

   // Bytes covered by the access
   always_comb
   begin
      case (size)
         SIZE_B:
         begin
            lane_mask = 8'h01 << addr[2:0];
         end
         SIZE_H:
         begin
            lane_mask = 8'h03 << {addr[2:1], 1'b0};
         end
         SIZE_W:
         begin
            lane_mask = 8'h0f << {addr[2], 2'b00};
         end
         default:
         begin
            lane_mask = 8'hff;
         end
      endcase
   end

   assign dram_we = {8{store_en}} & lane_mask;

   // ------------------------------
   // Load side
   // ------------------------------

   // Same word picked by lane at each width
   assign ld_b = rdata.b[ctx.lane];
   assign ld_h = rdata.h[ctx.lane[2:1]];
   assign ld_w = rdata.w[ctx.lane[2]];

   always_comb
   begin
      case (ctx.size)
         SIZE_B:
         begin
            ld_value = {{56{ctx.sigext & ld_b[7]}}, ld_b};
         end
         SIZE_H:
         begin
            ld_value = {{48{ctx.sigext & ld_h[15]}}, ld_h};
         end
         SIZE_W:
         begin
            ld_value = {{32{ctx.sigext & ld_w[31]}}, ld_w};
         end
         default:
         begin
            ld_value = rdata.d; // Doubleword as is
         end
      endcase
   end

endmodule

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

   // ------------------------------
   // Access size codes
   // ------------------------------
   localparam logic [3:0] SIZE_B = 4'd1;
   localparam logic [3:0] SIZE_H = 4'd2;
   localparam logic [3:0] SIZE_W = 4'd4;
   localparam logic [3:0] SIZE_D = 4'd8;

   localparam int DRAM_AW = 10; // Byte address width of data RAM

   // ------------------------------
   // Request and load context
   // ------------------------------
   typedef struct packed {
      logic        op_load;
      logic        op_store;
      logic        sigext;
      logic [3:0]  size;
      logic [63:0] base;
      logic [63:0] offset;
      logic [63:0] wdata;
   } mem_req_t;

   // Kept per load until its RAM word comes back
   typedef struct packed {
      logic [2:0] lane;
      logic [3:0] size;
      logic       sigext;
   } load_ctx_t;

   // ------------------------------
   // Four views of one RAM word
   // ------------------------------
   typedef union packed {
      logic [7:0][7:0]  b;
      logic [3:0][15:0] h;
      logic [1:0][31:0] w;
      logic [63:0]      d;
   } mem_word_u;

endpackage

// ==== source/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_valid,
   input  logic               op_load,
   input  logic               op_store,
   input  logic               sigext,
   input  logic [3:0]         size,
   input  logic [2:0]         addr_lane,
   input  logic               misaligned,
   input  logic [63:0]        ld_value,
   output logic               store_en,
   output logic               load_en,
   output lsu_pkg::load_ctx_t ctx,
   output logic [63:0]        result,
   output logic               result_valid,
   output logic               fault
);

   logic ld_pend; // Load word arrives next cycle
   logic bad_req;

   // ------------------------------
   // Request decode
   // ------------------------------
   assign store_en = req_valid & op_store & ~misaligned;
   assign load_en  = req_valid & op_load & ~misaligned;
   assign bad_req  = req_valid & (op_load | op_store) & misaligned;

   // ------------------------------
   // In-flight load
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ld_pend <= 1'b0;
      end
      else
      begin
         ld_pend <= load_en;
      end
   end

   always_ff @(posedge clk)
   begin
      if (load_en)
      begin
         ctx.lane   <= addr_lane;
         ctx.size   <= size;
         ctx.sigext <= sigext;
      end
   end

   // ------------------------------
   // Result and status pulses
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         result       <= 64'd0;
         result_valid <= 1'b0;
         fault        <= 1'b0;
      end
      else
      begin
         result_valid <= ld_pend;
         fault        <= bad_req; // Suppressed access
         if (ld_pend)
         begin
            result <= ld_value;
         end
      end
   end

endmodule

// ==== source/mem_unit.sv ====
`timescale 1ns/1ps

module mem_unit
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req_valid,
   input  lsu_pkg::mem_req_t req,
   output logic [63:0]       result,
   output logic              result_valid,
   output logic              fault
);

   import lsu_pkg::*;

   logic [63:0]        addr;
   logic               misaligned;
   logic               store_en;
   logic               load_en;
   load_ctx_t          ctx;
   logic [63:0]        ld_value;
   logic [DRAM_AW-1:0] dram_addr;
   logic [7:0]         dram_we;
   logic [63:0]        dram_din;
   mem_word_u          rdata;

   agu i_agu (
      .base       (req.base),
      .offset     (req.offset),
      .size       (req.size),
      .addr       (addr),
      .misaligned (misaligned)
   );

   mem_ctrl i_mem_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .op_load      (req.op_load),
      .op_store     (req.op_store),
      .sigext       (req.sigext),
      .size         (req.size),
      .addr_lane    (addr[2:0]), // Lane inside doubleword
      .misaligned   (misaligned),
      .ld_value     (ld_value),
      .store_en     (store_en),
      .load_en      (load_en),
      .ctx          (ctx),
      .result       (result),
      .result_valid (result_valid),
      .fault        (fault)
   );

   lsu #(.AW(DRAM_AW)) i_lsu (
      .addr      (addr),
      .size      (req.size),
      .wdata     (req.wdata),
      .store_en  (store_en),
      .ctx       (ctx),
      .rdata     (rdata),
      .dram_addr (dram_addr),
      .dram_we   (dram_we),
      .dram_din  (dram_din),
      .ld_value  (ld_value)
   );

   dram #(.AW(DRAM_AW)) i_dram (
      .clk  (clk),
      .addr (dram_addr),
      .we   (dram_we),
      .re   (load_en),
      .din  (dram_din),
      .dout (rdata)
   );

endmodule

// ==== verif/mem_unit_tb.sv ====
`timescale 1ns/1ps

module mem_unit_tb;

   import lsu_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 4;
   localparam int RAM_BYTES    = 2 ** DRAM_AW;
   localparam int FILL_OPS     = RAM_BYTES / 8;
   localparam int DIRECTED_OPS = 400; // Upper bound for directed sequences
   localparam int RAND_OPS     = 2000;
   localparam int TIMEOUT_NS   = (FILL_OPS + DIRECTED_OPS + RAND_OPS) * CLK_PERIOD * 4
                                 + RESET_CYCLES * CLK_PERIOD;

   localparam logic [63:0] STORE_BASE = 64'h100;
   localparam logic [63:0] LANE_BASE  = 64'h180;
   localparam logic [63:0] MIS_BASE   = 64'h200;
   localparam logic [63:0] B2B_BASE   = 64'h300;

   typedef logic [DRAM_AW-1:0] byte_idx_t;

   // Pending responses in request order
   typedef struct packed {
      logic        is_fault;
      int          due;    // Negedge count where the pulse is seen
      logic [63:0] value;
   } expect_t;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        req_valid;
   mem_req_t    req;
   logic [63:0] result;
   logic        result_valid;
   logic        fault;

   logic [7:0]  model_mem [0:RAM_BYTES-1];
   expect_t     exp_q [$];
   integer      seed = 32'h1fd1;
   int          cyc = 0;

   mem_unit i_mem_unit (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req          (req),
      .result       (result),
      .result_valid (result_valid),
      .fault        (fault)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ------------------------------
   // Reporting and model helpers
   // ------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "Run stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         abort_run($sformatf("Fail at %0t: %s got %h, expected %h", $time, name, got, exp));
      end
   endtask

   function automatic logic [63:0] rand64();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $random(seed);
      lo = $random(seed);
      return {hi, lo};
   endfunction

   function automatic logic is_misaligned(input logic [63:0] addr, input logic [3:0] size);
      logic [2:0] mask;
      mask = 3'(int'(size) - 1); // Size codes are byte counts
      return (addr[2:0] & mask) != 3'b000;
   endfunction

   function automatic logic [63:0] load_expect(input logic [63:0] addr, input logic [3:0] size,
                                               input logic sext);
      logic [63:0] value;
      byte_idx_t   idx;
      int          n;
      int          i;
      logic        neg;
      idx   = addr[DRAM_AW-1:0];
      n     = int'(size);
      value = '0;
      for (i = 0; i < n; i++)
      begin
         value[i*8 +: 8] = model_mem[idx + byte_idx_t'(i)];
      end
      neg = sext & value[n*8-1];
      for (i = n; i < 8; i++)
      begin
         value[i*8 +: 8] = {8{neg}};
      end
      return value;
   endfunction

   task automatic store_model(input logic [63:0] addr, input logic [3:0] size,
                              input logic [63:0] wdata);
      byte_idx_t idx;
      int        i;
      idx = addr[DRAM_AW-1:0];
      for (i = 0; i < int'(size); i++)
      begin
         model_mem[idx + byte_idx_t'(i)] = wdata[i*8 +: 8];
      end
   endtask

   // ------------------------------
   // Stimulus
   // ------------------------------
   task automatic send_req(input logic is_load, input logic [3:0] size, input logic sext,
                           input logic [63:0] addr, input logic [63:0] wdata);
      mem_req_t    nxt;
      expect_t     e;
      logic [63:0] off;
      off          = rand64();
      nxt.op_load  = is_load;
      nxt.op_store = ~is_load;
      nxt.sigext   = sext;
      nxt.size     = size;
      nxt.base     = addr - off; // Sum wraps back to addr
      nxt.offset   = off;
      nxt.wdata    = wdata;
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= nxt;
      if (is_misaligned(addr, size))
      begin
         e.is_fault = 1'b1;
         e.due      = cyc + 2;
         e.value    = '0;
         exp_q.push_back(e);
      end
      else if (is_load)
      begin
         e.is_fault = 1'b0;
         e.due      = cyc + 3;
         e.value    = load_expect(addr, size, sext);
         exp_q.push_back(e);
      end
      else
      begin
         store_model(addr, size, wdata);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
   endtask

   task automatic wait_for_drain();
      int i;
      i = 0;
      idle_cycles(1);
      while (exp_q.size() != 0 && i < 8)
      begin
         @(posedge clk);
         i++;
      end
   endtask

   // Every word gets a value tied to its address
   task automatic fill_ram();
      logic [63:0] a;
      for (int w = 0; w < RAM_BYTES; w += 8)
      begin
         a = 64'(w);
         send_req(1'b0, SIZE_D, 1'b0, a, {a[31:0] ^ 32'hc3a5_0f1e, ~a[31:0] + 32'h1357_9bdf});
      end
   endtask

   task automatic store_sizes_test();
      int         k;
      int         lane;
      logic [3:0] sz;
      for (k = 0; k < 4; k++)
      begin
         sz = 4'd1 << k;
         for (lane = 0; lane < 8; lane += int'(sz))
         begin
            send_req(1'b0, sz, 1'b0, STORE_BASE + 64'(lane), rand64());
            send_req(1'b1, SIZE_D, 1'b0, STORE_BASE, 64'd0);
         end
         send_req(1'b1, SIZE_D, 1'b0, STORE_BASE - 64'd8, 64'd0); // Neighbours untouched
         send_req(1'b1, SIZE_D, 1'b0, STORE_BASE + 64'd8, 64'd0);
      end
      wait_for_drain();
   endtask

   task automatic load_lanes_test();
      int         k;
      int         lane;
      int         sx;
      logic [3:0] sz;
      send_req(1'b0, SIZE_D, 1'b0, LANE_BASE, 64'h4f71_e25a_c436_0b97);
      for (k = 0; k < 4; k++)
      begin
         sz = 4'd1 << k;
         for (lane = 0; lane < 8; lane += int'(sz))
         begin
            for (sx = 0; sx < 2; sx++)
            begin
               send_req(1'b1, sz, sx[0], LANE_BASE + 64'(lane), rand64());
            end
         end
      end
      wait_for_drain();
   endtask

   task automatic misaligned_test();
      int         k;
      int         lane;
      logic [3:0] sz;
      for (k = 1; k < 4; k++)
      begin
         sz = 4'd1 << k;
         for (lane = 1; lane < 8; lane++)
         begin
            if ((lane % int'(sz)) != 0)
            begin
               send_req(1'b0, sz, 1'b0, MIS_BASE + 64'(lane), rand64());
               send_req(1'b1, sz, 1'b1, MIS_BASE + 64'(lane), 64'd0);
            end
         end
      end
      send_req(1'b1, SIZE_D, 1'b0, MIS_BASE, 64'd0);
      send_req(1'b1, SIZE_D, 1'b0, MIS_BASE + 64'd8, 64'd0);
      wait_for_drain();
   endtask

   task automatic back_to_back_test();
      send_req(1'b0, SIZE_D, 1'b0, B2B_BASE, 64'h8000_7fff_ff01_80c3);
      send_req(1'b1, SIZE_D, 1'b0, B2B_BASE, 64'd0);
      send_req(1'b0, SIZE_B, 1'b0, B2B_BASE + 64'd5, 64'h0000_0000_0000_00a6);
      send_req(1'b1, SIZE_B, 1'b1, B2B_BASE + 64'd5, 64'd0);
      send_req(1'b1, SIZE_H, 1'b1, B2B_BASE + 64'd4, 64'd0);
      send_req(1'b1, SIZE_W, 1'b0, B2B_BASE + 64'd4, 64'd0);
      send_req(1'b1, SIZE_H, 1'b0, B2B_BASE + 64'd3, 64'd0); // Fault between loads
      send_req(1'b1, SIZE_D, 1'b0, B2B_BASE, 64'd0);
      wait_for_drain();
   endtask

   task automatic random_test();
      int          sent;
      logic [31:0] r;
      logic [31:0] ra;
      logic [3:0]  sz;
      logic [63:0] a;
      sent = 0;
      while (sent < RAND_OPS)
      begin
         r  = $random(seed);
         ra = $random(seed);
         if (r[6:0] < 7'd90)
         begin
            sz = 4'd1 << r[8:7];
            if (r[15:12] == 4'd0)
            begin
               a = rand64(); // Upper bits alias
            end
            else
            begin
               a = 64'(ra[DRAM_AW-1:0]);
            end
            if (r[18:16] != 3'd0)
            begin
               a = a & ~(64'(sz) - 64'd1);
            end
            send_req(r[9], sz, r[10], a, rand64());
            sent++;
         end
         else
         begin
            idle_cycles(1);
         end
      end
      wait_for_drain();
   endtask

   // ------------------------------
   // Response monitor
   // ------------------------------
   always @(negedge clk)
   begin
      expect_t e_ld;
      logic    exp_rv;
      logic    exp_flt;
      cyc = cyc + 1;
      if (rst_n)
      begin
         exp_rv  = 1'b0;
         exp_flt = 1'b0;
         e_ld    = '0;
         if ((result_valid || fault) && exp_q.size() == 0)
         begin
            abort_run("A result or fault pulse came with no request pending");
         end
         else
         begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc && !exp_q[0].is_fault)
            begin
               exp_rv = 1'b1;
               e_ld   = exp_q.pop_front();
            end
            if (exp_q.size() > 0 && exp_q[0].due == cyc && exp_q[0].is_fault)
            begin
               exp_flt = 1'b1;
               exp_q.delete(0);
            end
            check_value("result_valid", 64'(result_valid), 64'(exp_rv));
            check_value("fault", 64'(fault), 64'(exp_flt));
            if (exp_rv)
            begin
               check_value("result", result, e_ld.value);
            end
         end
      end
   end

   initial
   begin
      #(TIMEOUT_NS);
      abort_run("Timeout: the run did not finish in time");
   end

   initial
   begin
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      idle_cycles(4); // Outputs must stay quiet
      @(negedge clk);
      check_value("result", result, 64'd0);
      fill_ram();
      wait_for_drain();
      store_sizes_test();
      load_lanes_test();
      misaligned_test();
      back_to_back_test();
      random_test();
      if (exp_q.size() != 0)
      begin
         abort_run("Requests were still pending at the end of the run");
      end
      else
      begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule
